/* hdl/noc_rx_pkg.sv */
package noc_rx_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int FLIT_DATA_WIDTH    = 64;
  localparam int PACKET_TYPE_WIDTH  = 2;
  localparam int ID_WIDTH           = 8;
  localparam int VC_FIELD_WIDTH     = 2;
  localparam int TAG_WIDTH          = 8;
  localparam int STATUS_WIDTH       = 2;
  localparam int ADDRESS_WIDTH      = 32;
  localparam int BURST_CODE_WIDTH   = 8;   // encoded length in the header.
  localparam int BURST_LENGTH_WIDTH = 9;   // decoded length, up to 256.
  localparam int BURST_SIZE_WIDTH   = 3;
  localparam int BURST_TYPE_WIDTH   = 2;
  localparam int DATA_WIDTH         = 32;
  localparam int BYTE_ENABLE_WIDTH  = 4;

  ////////////////////
  // header flit 0
  ////////////////////
  localparam int TYPE_LSB        = 0;
  localparam int DESTINATION_LSB = 2;
  localparam int SOURCE_LSB      = 10;
  localparam int VC_LSB          = 18;
  localparam int TAG_LSB         = 20;
  localparam int STATUS_LSB      = 28;   // responses only.

  ////////////////////
  // header flit 1
  ////////////////////
  localparam int ADDRESS_LSB     = 0;
  localparam int BURST_CODE_LSB  = 32;
  localparam int BURST_SIZE_LSB  = 40;
  localparam int BURST_TYPE_LSB  = 43;

  // bit 1 marks a response.
  typedef enum logic [PACKET_TYPE_WIDTH-1:0] {
    read_request   = 2'b00,
    write_request  = 2'b01,
    read_response  = 2'b10,
    write_response = 2'b11
  } packet_type_e;

  typedef enum logic {
    write_payload = 1'b0,
    read_payload  = 1'b1
  } payload_type_e;

  // one payload flit, seen as write data or as read data.
  typedef union packed {
    struct packed {
      logic [FLIT_DATA_WIDTH-BYTE_ENABLE_WIDTH-DATA_WIDTH-1:0] reserved;
      logic [BYTE_ENABLE_WIDTH-1:0]                           byte_enable;
      logic [DATA_WIDTH-1:0]                                  data;
    } write_view;
    struct packed {
      logic [FLIT_DATA_WIDTH-STATUS_WIDTH-DATA_WIDTH-1:0] reserved;
      logic [STATUS_WIDTH-1:0]                           status;
      logic [DATA_WIDTH-1:0]                             data;
    } read_view;
  } payload_word_u;

  function automatic logic [BURST_LENGTH_WIDTH-1:0] decode_burst_length(
    input logic [BURST_CODE_WIDTH-1:0] code
  );
    if (code == '0) begin
      return BURST_LENGTH_WIDTH'(256);   // zero encodes the longest burst.
    end
    return {1'b0, code};
  endfunction

endpackage

/* hdl/noc_vc_fifo.sv */
module noc_vc_fifo
  import noc_rx_pkg::*;
#(
  parameter int FIFO_DEPTH = 4
)(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push,
  input  logic                       push_header,
  input  logic                       push_tail,
  input  logic [FLIT_DATA_WIDTH-1:0] push_data,
  input  logic                       pop,
  output logic                       empty,
  output logic                       head_header,
  output logic                       head_tail,
  output logic [FLIT_DATA_WIDTH-1:0] head_data,
  output logic                       credit
);

  localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  logic [FLIT_DATA_WIDTH+1:0] mem [FIFO_DEPTH];   // {header, tail, data}.
  logic [PTR_WIDTH-1:0]       wr_ptr;
  logic [PTR_WIDTH-1:0]       rd_ptr;
  logic [COUNT_WIDTH-1:0]     count;
  logic                       do_pop;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty  = (count == '0);
  assign do_pop = pop && !empty;
  assign credit = do_pop;   // one credit back per flit leaving.

  assign {head_header, head_tail, head_data} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {push_header, push_tail, push_data};
    end
  end

  // the sender's credits keep push away from a full queue.
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* hdl/noc_vc_selector.sv */
module noc_vc_selector
  import noc_rx_pkg::*;
#(
  parameter int   CHANNELS   = 2,
  parameter int   FIFO_DEPTH = 4,
  localparam int  VC_BITS    = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
)(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       flit_valid,
  input  logic [VC_BITS-1:0]         flit_vc,
  input  logic                       flit_header,
  input  logic                       flit_tail,
  input  logic [FLIT_DATA_WIDTH-1:0] flit_data,
  output logic [CHANNELS-1:0]        credit_return,
  output logic                       sel_valid,
  output logic                       sel_header,
  output logic                       sel_tail,
  output logic [FLIT_DATA_WIDTH-1:0] sel_data,
  input  logic                       sel_ready
);

  logic [CHANNELS-1:0]        push;
  logic [CHANNELS-1:0]        pop;
  logic [CHANNELS-1:0]        empty;
  logic [CHANNELS-1:0]        head_header;
  logic [CHANNELS-1:0]        head_tail;
  logic [FLIT_DATA_WIDTH-1:0] head_data [CHANNELS];
  logic                       busy;       // a packet is in flight.
  logic [VC_BITS-1:0]         grant;      // held or last granted channel.
  logic [VC_BITS-1:0]         next_grant;
  logic [VC_BITS-1:0]         current;
  logic                       found;

  for (genvar i = 0; i < CHANNELS; i++) begin : g_channel
    assign push[i] = flit_valid && (flit_vc == VC_BITS'(i));
    assign pop[i]  = sel_valid && sel_ready && (current == VC_BITS'(i));

    noc_vc_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_noc_vc_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .push        (push[i]),
      .push_header (flit_header),
      .push_tail   (flit_tail),
      .push_data   (flit_data),
      .pop         (pop[i]),
      .empty       (empty[i]),
      .head_header (head_header[i]),
      .head_tail   (head_tail[i]),
      .head_data   (head_data[i]),
      .credit      (credit_return[i])
    );
  end

  ////////////////////
  // round robin
  ////////////////////
  always_comb begin
    int idx;
    found      = 1'b0;
    next_grant = grant;
    for (int k = 1; k <= CHANNELS; k++) begin
      idx = (int'(grant) + k) % CHANNELS;   // start after the last winner.
      if (!found && !empty[idx]) begin
        found      = 1'b1;
        next_grant = VC_BITS'(idx);
      end
    end
  end

  assign current    = busy ? grant : next_grant;
  assign sel_valid  = busy ? !empty[grant] : found;
  assign sel_header = head_header[current];
  assign sel_tail   = head_tail[current];
  assign sel_data   = head_data[current];

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      grant <= VC_BITS'(CHANNELS - 1);   // channel 0 wins first.
    end else if (sel_valid) begin
      busy  <= !(sel_ready && sel_tail);   // held from first offer to tail.
      grant <= current;
    end
  end

endmodule

/* hdl/noc_packet_unpacker.sv */
module noc_packet_unpacker
  import noc_rx_pkg::*;
#(
  parameter int   CHANNELS   = 2,
  parameter int   FIFO_DEPTH = 4,
  localparam int  VC_BITS    = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
)(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flit_valid,
  input  logic [VC_BITS-1:0]            flit_vc,
  input  logic                          flit_header,
  input  logic                          flit_tail,
  input  logic [FLIT_DATA_WIDTH-1:0]    flit_data,
  output logic [CHANNELS-1:0]           credit_return,
  output logic                          header_valid,
  input  logic                          header_ready,
  output packet_type_e                  packet_type,
  output logic [ID_WIDTH-1:0]           destination_id,
  output logic [ID_WIDTH-1:0]           source_id,
  output logic [VC_FIELD_WIDTH-1:0]     vc,
  output logic [TAG_WIDTH-1:0]          tag,
  output logic [BURST_TYPE_WIDTH-1:0]   burst_type,
  output logic [BURST_LENGTH_WIDTH-1:0] burst_length,
  output logic [BURST_SIZE_WIDTH-1:0]   burst_size,
  output logic [ADDRESS_WIDTH-1:0]      address,
  output logic [STATUS_WIDTH-1:0]       packet_status,
  output logic                          payload_valid,
  input  logic                          payload_ready,
  output payload_type_e                 payload_type,
  output logic                          payload_last,
  output logic [DATA_WIDTH-1:0]         data,
  output logic [BYTE_ENABLE_WIDTH-1:0]  byte_enable,
  output logic [STATUS_WIDTH-1:0]       payload_status
);

  logic                       sel_valid;
  logic                       sel_header;
  logic                       sel_tail;
  logic [FLIT_DATA_WIDTH-1:0] sel_data;
  logic                       sel_ready;
  logic                       header_flit_valid;
  logic                       header_flit_ready;
  logic                       header_last;
  logic                       flit_count;      // set while flit 0 is buffered.
  logic [FLIT_DATA_WIDTH-1:0] header_buffer;
  logic [FLIT_DATA_WIDTH-1:0] header0;
  logic                       is_response;
  payload_word_u              word;

  noc_vc_selector #(
    .CHANNELS   (CHANNELS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_noc_vc_selector (
    .clk           (clk),
    .rst_n         (rst_n),
    .flit_valid    (flit_valid),
    .flit_vc       (flit_vc),
    .flit_header   (flit_header),
    .flit_tail     (flit_tail),
    .flit_data     (flit_data),
    .credit_return (credit_return),
    .sel_valid     (sel_valid),
    .sel_header    (sel_header),
    .sel_tail      (sel_tail),
    .sel_data      (sel_data),
    .sel_ready     (sel_ready)
  );

  assign header_flit_valid = sel_valid && sel_header;
  assign sel_ready         = sel_header ? header_flit_ready : payload_ready;

  ////////////////////
  // header
  ////////////////////
  assign header0     = flit_count ? header_buffer : sel_data;
  assign is_response = header0[TYPE_LSB+1];
  assign header_last = is_response || flit_count;

  // flit 0 of a request is taken without waiting on the consumer.
  assign header_valid      = header_flit_valid && header_last;
  assign header_flit_ready = header_last ? header_ready : 1'b1;

  assign packet_type    = packet_type_e'(header0[TYPE_LSB +: PACKET_TYPE_WIDTH]);
  assign destination_id = header0[DESTINATION_LSB +: ID_WIDTH];
  assign source_id      = header0[SOURCE_LSB +: ID_WIDTH];
  assign vc             = header0[VC_LSB +: VC_FIELD_WIDTH];
  assign tag            = header0[TAG_LSB +: TAG_WIDTH];
  assign packet_status  = header0[STATUS_LSB +: STATUS_WIDTH];
  assign address        = sel_data[ADDRESS_LSB +: ADDRESS_WIDTH];
  assign burst_length   = decode_burst_length(sel_data[BURST_CODE_LSB +: BURST_CODE_WIDTH]);
  assign burst_size     = sel_data[BURST_SIZE_LSB +: BURST_SIZE_WIDTH];
  assign burst_type     = sel_data[BURST_TYPE_LSB +: BURST_TYPE_WIDTH];

  always_ff @(posedge clk) begin
    if (header_flit_valid && !header_last) begin
      header_buffer <= sel_data;
    end
  end

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      flit_count   <= 1'b0;
      payload_type <= write_payload;
    end else if (header_flit_valid && header_flit_ready) begin
      flit_count <= !header_last;
      if (header_last) begin
        payload_type <= is_response ? read_payload : write_payload;
      end
    end
  end

  ////////////////////
  // payload
  ////////////////////
  assign word           = sel_data;
  assign payload_valid  = sel_valid && !sel_header;
  assign payload_last   = sel_tail;
  assign data           = word.write_view.data;
  assign byte_enable    = word.write_view.byte_enable;
  assign payload_status = word.read_view.status;

endmodule

/* hdl/noc_endpoint_rx.sv */
module noc_endpoint_rx
  import noc_rx_pkg::*;
#(
  parameter int   CHANNELS   = 2,
  parameter int   FIFO_DEPTH = 4,
  localparam int  VC_BITS    = (CHANNELS > 1) ? $clog2(CHANNELS) : 1
)(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          flit_valid,
  input  logic [VC_BITS-1:0]            flit_vc,
  input  logic                          flit_header,
  input  logic                          flit_tail,
  input  logic [FLIT_DATA_WIDTH-1:0]    flit_data,
  output logic [CHANNELS-1:0]           credit_return,
  output logic                          header_valid,
  input  logic                          header_ready,
  output packet_type_e                  packet_type,
  output logic [ID_WIDTH-1:0]           destination_id,
  output logic [ID_WIDTH-1:0]           source_id,
  output logic [VC_FIELD_WIDTH-1:0]     vc,
  output logic [TAG_WIDTH-1:0]          tag,
  output logic [BURST_TYPE_WIDTH-1:0]   burst_type,
  output logic [BURST_LENGTH_WIDTH-1:0] burst_length,
  output logic [BURST_SIZE_WIDTH-1:0]   burst_size,
  output logic [ADDRESS_WIDTH-1:0]      address,
  output logic [STATUS_WIDTH-1:0]       packet_status,
  output logic                          payload_valid,
  input  logic                          payload_ready,
  output payload_type_e                 payload_type,
  output logic                          payload_last,
  output logic [DATA_WIDTH-1:0]         data,
  output logic [BYTE_ENABLE_WIDTH-1:0]  byte_enable,
  output logic [STATUS_WIDTH-1:0]       payload_status
);

  noc_packet_unpacker #(
    .CHANNELS   (CHANNELS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_noc_packet_unpacker (
    .clk            (clk),
    .rst_n          (rst_n),
    .flit_valid     (flit_valid),
    .flit_vc        (flit_vc),
    .flit_header    (flit_header),
    .flit_tail      (flit_tail),
    .flit_data      (flit_data),
    .credit_return  (credit_return),
    .header_valid   (header_valid),
    .header_ready   (header_ready),
    .packet_type    (packet_type),
    .destination_id (destination_id),
    .source_id      (source_id),
    .vc             (vc),
    .tag            (tag),
    .burst_type     (burst_type),
    .burst_length   (burst_length),
    .burst_size     (burst_size),
    .address        (address),
    .packet_status  (packet_status),
    .payload_valid  (payload_valid),
    .payload_ready  (payload_ready),
    .payload_type   (payload_type),
    .payload_last   (payload_last),
    .data           (data),
    .byte_enable    (byte_enable),
    .payload_status (payload_status)
  );

endmodule

/* testbench/tb_noc_endpoint_rx.sv */
module tb_noc_endpoint_rx
  import noc_rx_pkg::*;
();

  localparam int CHANNELS   = 2;
  localparam int FIFO_DEPTH = 4;
  localparam int PACKETS    = 200;
  localparam int TIMEOUT    = 4000;

  logic                          clk;
  logic                          rst_n;
  logic                          flit_valid;
  logic [$clog2(CHANNELS)-1:0]   flit_vc;
  logic                          flit_header, flit_tail;
  logic [FLIT_DATA_WIDTH-1:0]    flit_data;
  logic [CHANNELS-1:0]           credit_return;
  logic                          header_valid, header_ready;
  packet_type_e                  packet_type;
  logic [ID_WIDTH-1:0]           destination_id, source_id;
  logic [VC_FIELD_WIDTH-1:0]     vc;
  logic [TAG_WIDTH-1:0]          tag;
  logic [BURST_TYPE_WIDTH-1:0]   burst_type;
  logic [BURST_LENGTH_WIDTH-1:0] burst_length;
  logic [BURST_SIZE_WIDTH-1:0]   burst_size;
  logic [ADDRESS_WIDTH-1:0]      address;
  logic [STATUS_WIDTH-1:0]       packet_status;
  logic                          payload_valid, payload_ready;
  payload_type_e                 payload_type;
  logic                          payload_last;
  logic [DATA_WIDTH-1:0]         data;
  logic [BYTE_ENABLE_WIDTH-1:0]  byte_enable;
  logic [STATUS_WIDTH-1:0]       payload_status;

  logic [63:0] exp_flit0 [CHANNELS][$];   // expected packets, oldest first.
  logic [63:0] exp_flit1 [CHANNELS][$];
  int          exp_count [CHANNELS][$];
  logic [63:0] exp_words [CHANNELS][$];
  int          sent [CHANNELS];
  int          returned [CHANNELS];
  int          errors, done_packets, cur_vc, cur_left;
  bit          in_payload, resp, hold_header, hold_payload;
  logic [75:0] header_bus, last_header;
  logic [39:0] payload_bus, last_payload;

  noc_endpoint_rx #(
    .CHANNELS   (CHANNELS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_noc_endpoint_rx (.*);

  assign header_bus  = {packet_type, destination_id, source_id, vc, tag, burst_type,
                        burst_length, burst_size, address, packet_status};
  assign payload_bus = {payload_type, payload_last, data, byte_enable, payload_status};

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [95:0] exp, input logic [95:0] act);
    $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
    errors++;
  endtask

  task automatic report_failure(input string what);
    $display("ERROR: %s", what);
    errors++;
  endtask

  task automatic check_field(input string name, input logic [95:0] exp, input logic [95:0] act);
    assert (act == exp) else report_mismatch(name, exp, act);
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("Verification failed");
    $finish;
  endtask

  // one flit on the link, after a random gap and once the channel has credit.
  task automatic send_flit(input int ch, input logic hdr, input logic tl, input logic [63:0] word);
    int waited;
    waited = 0;
    repeat ($urandom_range(2)) @(negedge clk);
    while (FIFO_DEPTH - sent[ch] + returned[ch] == 0) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("no credit came back on a stalled channel");
    end
    flit_valid  = 1'b1;
    flit_vc     = ch[0];
    flit_header = hdr;
    flit_tail   = tl;
    flit_data   = word;
    sent[ch]++;
    @(negedge clk);
    flit_valid  = 1'b0;
  endtask

  ////////////////////
  // consumer
  ////////////////////
  initial begin
    header_ready  = 1'b0;
    payload_ready = 1'b0;
    forever begin
      @(negedge clk);
      header_ready  = ($urandom_range(3) != 0);
      payload_ready = ($urandom_range(3) != 0);
    end
  end

  ////////////////////
  // monitor and model
  ////////////////////
  always @(posedge clk) begin
    logic [63:0] f0, f1, w;
    int          hv;
    if (rst_n) begin
      for (int c = 0; c < CHANNELS; c++) begin
        if (credit_return[c]) returned[c]++;
        assert (returned[c] <= sent[c]) else report_failure("credit counter above queue depth");
      end
      if (hold_header) begin   // a stalled header keeps its fields.
        assert (header_valid && header_bus == last_header)
          else report_failure("header outputs changed while stalled");
      end
      if (hold_payload) begin
        assert (payload_valid && payload_bus == last_payload)
          else report_failure("payload outputs changed while stalled");
      end
      hold_header  = header_valid && !header_ready;
      hold_payload = payload_valid && !payload_ready;
      last_header  = header_bus;
      last_payload = payload_bus;
      if (header_valid && header_ready) begin
        hv = int'(vc);
        assert (!in_payload) else report_failure("header accepted inside another packet");
        assert (hv < CHANNELS && exp_flit0[hv].size() > 0)
          else report_failure("header accepted with no packet expected on its channel");
        if (hv < CHANNELS && exp_flit0[hv].size() > 0) begin
          f0 = exp_flit0[hv].pop_front();
          f1 = exp_flit1[hv].pop_front();
          cur_left = exp_count[hv].pop_front();
          check_field("header.packet_type", 96'(f0[1:0]), 96'(packet_type));
          check_field("header.destination_id", 96'(f0[9:2]), 96'(destination_id));
          check_field("header.source_id", 96'(f0[17:10]), 96'(source_id));
          check_field("header.tag", 96'(f0[27:20]), 96'(tag));
          if (f0[1]) begin
            check_field("header.packet_status", 96'(f0[29:28]), 96'(packet_status));
          end else begin
            check_field("header.address", 96'(f1[31:0]), 96'(address));
            check_field("header.burst_length", (f1[39:32] == 8'd0) ? 96'd256 : 96'(f1[39:32]),
                        96'(burst_length));
            check_field("header.burst_size", 96'(f1[42:40]), 96'(burst_size));
            check_field("header.burst_type", 96'(f1[44:43]), 96'(burst_type));
          end
          resp       = f0[1];
          cur_vc     = hv;
          in_payload = (cur_left > 0);
          if (cur_left == 0) done_packets++;
        end
      end
      if (payload_valid && payload_ready) begin
        assert (in_payload) else report_failure("payload transfer with no open packet");
        if (in_payload) begin
          w = exp_words[cur_vc].pop_front();
          cur_left--;
          check_field("payload.data", 96'(w[31:0]), 96'(data));
          check_field("payload.type", 96'(resp), 96'(payload_type));
          check_field("payload.last", 96'(cur_left == 0), 96'(payload_last));
          if (resp) check_field("payload.status", 96'(w[33:32]), 96'(payload_status));
          else check_field("payload.byte_enable", 96'(w[35:32]), 96'(byte_enable));
          if (cur_left == 0) begin
            in_payload = 1'b0;
            done_packets++;
          end
        end
      end
    end
  end

  ////////////////////
  // packet source
  ////////////////////
  initial begin
    int          ch, n, waited;
    logic [1:0]  kind;
    logic [63:0] f0, f1, w;
    void'($urandom(32'hb608));
    rst_n       = 1'b0;
    flit_valid  = 1'b0;
    flit_vc     = '0;
    flit_header = 1'b0;
    flit_tail   = 1'b0;
    flit_data   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    assert (!header_valid && !payload_valid && credit_return == '0)
      else report_failure("outputs not idle during reset");
    rst_n = 1'b1;
    for (int p = 0; p < PACKETS; p++) begin
      ch   = $urandom_range(CHANNELS - 1);
      kind = 2'($urandom_range(3));
      n    = (kind == write_request || kind == read_response) ? $urandom_range(4, 1) : 0;
      f0   = {$urandom, $urandom};
      f1   = {$urandom, $urandom};
      f0[1:0]   = kind;
      f0[19:18] = 2'(ch);
      if (kind == write_request) f1[39:32] = 8'(n);   // code equals the payload count.
      exp_flit0[ch].push_back(f0);
      exp_flit1[ch].push_back(f1);
      exp_count[ch].push_back(n);
      send_flit(ch, 1'b1, kind == write_response, f0);
      if (!kind[1]) send_flit(ch, 1'b1, n == 0, f1);
      for (int i = 0; i < n; i++) begin
        w = {$urandom, $urandom};
        exp_words[ch].push_back(w);
        send_flit(ch, 1'b0, i == n - 1, w);
      end
    end
    waited = 0;
    while (done_packets < PACKETS) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) abort_run("packets still outstanding at the end of the run");
    end
    for (int c = 0; c < CHANNELS; c++) begin
      check_field("credits.final", 96'(FIFO_DEPTH), 96'(FIFO_DEPTH - sent[c] + returned[c]));
    end
    $display("packets: %0d, errors: %0d", done_packets, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* noc_endpoint_rx.f */
hdl/noc_rx_pkg.sv
hdl/noc_vc_fifo.sv
hdl/noc_vc_selector.sv
hdl/noc_packet_unpacker.sv
hdl/noc_endpoint_rx.sv
testbench/tb_noc_endpoint_rx.sv

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f noc_endpoint_rx.f \
  --top-module tb_noc_endpoint_rx \
  -o tb_noc_endpoint_rx

./obj_dir/tb_noc_endpoint_rx | tee sim.log

if grep -q "Verification failed" sim.log; then
  exit 1
fi
